// ==== list.f ====
common/vde_pkg.sv
common/heap_cmd_if.sv
common/heap_mem_if.sv
design/cmd_intake.sv
heap/heap_store.sv
heap/heap_engine.sv
design/decision_fifo.sv
design/vde_top.sv
tb/vde_asserts.sv
tb/tb_vde.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_vde -f list.f -Mdir obj_dir
	./obj_dir/Vtb_vde > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/tb_vde.sv ====
`timescale 1ns/1ps
module tb_vde;
    import vde_pkg::*;

    localparam int CMD_TIMEOUT   = 500;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int MIX_CMDS      = 600;

    logic             clk;
    logic             reset;
    logic             cmd_valid;
    op_e              cmd_op;
    logic [VAR_W-1:0] cmd_var;
    logic             cmd_value;
    logic             cmd_ready;
    logic             dec_valid;
    logic [VAR_W-1:0] dec_var;
    logic             dec_phase;
    logic             dec_empty;
    logic             dec_ready;
    logic             busy;

    // Reference model of the variable state
    int unsigned score_m    [1:MAX_VARS];
    bit          assigned_m [1:MAX_VARS];
    bit          phase_m    [1:MAX_VARS];
    int          count_m;

    // Decisions issued and not yet seen at the output
    int          exp_var_q   [$];
    bit          exp_phase_q [$];
    bit          exp_empty_q [$];
    string       exp_name_q  [$];

    logic [31:0] rng_state;
    string       test_name;
    int          ready_mode;    // 0 hold low, 1 hold high, 2 random

    vde_top DUT (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_var   (cmd_var),
        .cmd_value (cmd_value),
        .cmd_ready (cmd_ready),
        .dec_valid (dec_valid),
        .dec_var   (dec_var),
        .dec_phase (dec_phase),
        .dec_empty (dec_empty),
        .dec_ready (dec_ready),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ============================
    // Helpers
    // ============================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % n);
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic timeout_error(input string what);
        $display("Timeout in test %s: %s", test_name, what);
        abort_run();
    endtask

    // Every falling edge goes through here, so dec_ready follows the mode
    task automatic next_negedge();
        @(negedge clk);
        case (ready_mode)
            0:       dec_ready = 1'b0;
            1:       dec_ready = 1'b1;
            default: dec_ready = (rand_below(2) != 0);
        endcase
    endtask

    // Top unassigned variable with ties going to the lower number
    function automatic void expect_decision();
        int best;
        best = 0;
        for (int v = 1; v <= count_m; v++) begin
            if (!assigned_m[v] && (best == 0 || score_m[v] > score_m[best])) begin
                best = v;
            end
        end
        exp_var_q.push_back(best);
        exp_phase_q.push_back(best == 0 ? 1'b0 : phase_m[best]);
        exp_empty_q.push_back(best == 0);
        exp_name_q.push_back(test_name);
    endfunction

    function automatic void apply_model(input op_e op, input int v, input bit value);
        bit in_range;
        in_range = (v >= 1) && (v <= count_m);
        case (op)
            OP_INIT: begin
                count_m = (v < 1 || v > MAX_VARS) ? 0 : v;
                for (int i = 1; i <= MAX_VARS; i++) begin
                    score_m[i]    = 0;
                    assigned_m[i] = 1'b0;
                    phase_m[i]    = 1'b0;
                end
            end
            OP_ASSIGN: if (in_range) begin
                assigned_m[v] = 1'b1;
                phase_m[v]    = value;
            end
            OP_UNASSIGN: if (in_range) assigned_m[v] = 1'b0;
            OP_BUMP:     if (in_range) score_m[v] += BUMP_INCREMENT;
            OP_DECIDE:   expect_decision();
            default: ;
        endcase
    endfunction

    task automatic send_cmd(input op_e op, input int v, input bit value);
        int waited;
        waited = 0;
        next_negedge();
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_var   = VAR_W'(v);
        cmd_value = value;
        while (!cmd_ready) begin
            waited++;
            if (waited > CMD_TIMEOUT) timeout_error("command was not accepted");
            next_negedge();
        end
        // Transfer happens at the coming rising edge
        apply_model(op, v, value);
        next_negedge();
        cmd_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        ready_mode = 1;
        next_negedge();
        while (exp_var_q.size() != 0 || busy || dec_valid) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) timeout_error("decisions did not drain");
            next_negedge();
        end
    endtask

    task automatic random_mix();
        int pick;
        int v;
        for (int n = 0; n < MIX_CMDS; n++) begin
            pick = rand_below(100);
            v = (count_m == 0) ? rand_below(4) : 1 + rand_below(count_m);
            if (rand_below(8) == 0) v = rand_below(128);
            if (pick < 3) begin
                send_cmd(OP_INIT, rand_below(72), 1'b0);
            end else if (pick < 35) begin
                send_cmd(OP_ASSIGN, v, rand_below(2) != 0);
            end else if (pick < 60) begin
                send_cmd(OP_UNASSIGN, v, 1'b0);
            end else if (pick < 82) begin
                send_cmd(OP_BUMP, v, 1'b0);
            end else begin
                send_cmd(OP_DECIDE, 0, 1'b0);
            end
        end
    endtask

    // Decisions are taken at the rising edge where valid and ready meet
    always @(posedge clk) begin
        if (!reset && dec_valid && dec_ready) begin
            if (exp_var_q.size() == 0) begin
                $display("Unexpected decision in test %s: none was issued", test_name);
                abort_run();
            end
            check_value({exp_name_q[0], " var"}, exp_var_q[0], dec_var);
            check_value({exp_name_q[0], " phase"}, exp_phase_q[0], dec_phase);
            check_value({exp_name_q[0], " empty"}, exp_empty_q[0], dec_empty);
            void'(exp_var_q.pop_front());
            void'(exp_phase_q.pop_front());
            void'(exp_empty_q.pop_front());
            void'(exp_name_q.pop_front());
        end
    end

    // ============================
    // Tests
    // ============================
    initial begin
        reset            = 1'b1;
        cmd_valid        = 1'b0;
        cmd_op           = OP_INIT;
        cmd_var          = '0;
        cmd_value        = 1'b0;
        dec_ready        = 1'b1;
        rng_state        = 32'ha942_1d67;
        ready_mode       = 1;
        count_m          = 0;
        test_name        = "reset";
        apply_model(OP_INIT, 0, 1'b0);
        repeat (10) next_negedge();
        reset = 1'b0;
        next_negedge();
        check_value("reset cmd_ready", 1, cmd_ready);
        check_value("reset dec_valid", 0, dec_valid);
        check_value("reset busy", 0, busy);
        send_cmd(OP_DECIDE, 0, 1'b0);
        wait_drain();

        test_name = "init_order";
        send_cmd(OP_INIT, 20, 1'b0);
        send_cmd(OP_DECIDE, 0, 1'b0);
        wait_drain();

        test_name = "random_bumps";
        for (int i = 0; i < 40; i++) begin
            send_cmd(OP_BUMP, 1 + rand_below(20), 1'b0);
            if (i % 4 == 3) send_cmd(OP_DECIDE, 0, 1'b0);
        end
        wait_drain();

        test_name = "assign_unassign";
        send_cmd(OP_INIT, 10, 1'b0);
        send_cmd(OP_ASSIGN, 3, 1'b1);
        send_cmd(OP_DECIDE, 0, 1'b0);
        repeat (3) send_cmd(OP_BUMP, 3, 1'b0);
        send_cmd(OP_DECIDE, 0, 1'b0);
        send_cmd(OP_UNASSIGN, 3, 1'b0);
        send_cmd(OP_DECIDE, 0, 1'b0);
        send_cmd(OP_ASSIGN, 5, 1'b1);
        send_cmd(OP_UNASSIGN, 5, 1'b0);
        repeat (4) send_cmd(OP_BUMP, 5, 1'b0);
        send_cmd(OP_DECIDE, 0, 1'b0);
        wait_drain();

        test_name = "empty_set";
        send_cmd(OP_INIT, 6, 1'b0);
        for (int v = 1; v <= 6; v++) send_cmd(OP_ASSIGN, v, v[0]);
        send_cmd(OP_DECIDE, 0, 1'b0);
        send_cmd(OP_UNASSIGN, 4, 1'b0);
        send_cmd(OP_DECIDE, 0, 1'b0);
        send_cmd(OP_INIT, 0, 1'b0);
        send_cmd(OP_DECIDE, 0, 1'b0);
        send_cmd(OP_INIT, 100, 1'b0);
        send_cmd(OP_DECIDE, 0, 1'b0);
        wait_drain();

        test_name = "out_of_range";
        send_cmd(OP_INIT, 8, 1'b0);
        send_cmd(OP_BUMP, 2, 1'b0);
        send_cmd(OP_ASSIGN, 0, 1'b1);
        send_cmd(OP_ASSIGN, 9, 1'b1);
        send_cmd(OP_UNASSIGN, 0, 1'b0);
        send_cmd(OP_BUMP, 9, 1'b0);
        send_cmd(OP_BUMP, 100, 1'b0);
        send_cmd(OP_ASSIGN, 127, 1'b0);
        send_cmd(OP_DECIDE, 0, 1'b0);
        wait_drain();

        test_name = "back_pressure";
        send_cmd(OP_BUMP, 7, 1'b0);
        ready_mode = 0;
        send_cmd(OP_DECIDE, 0, 1'b0);
        send_cmd(OP_BUMP, 4, 1'b0);
        send_cmd(OP_BUMP, 4, 1'b0);
        send_cmd(OP_DECIDE, 0, 1'b0);
        send_cmd(OP_ASSIGN, 4, 1'b1);
        send_cmd(OP_DECIDE, 0, 1'b0);
        // Third decide sits in the intake while the queue is full
        repeat (4) begin
            check_value("back_pressure cmd_ready", 0, cmd_ready);
            check_value("back_pressure dec_valid", 1, dec_valid);
            next_negedge();
        end
        wait_drain();

        test_name = "random_mix";
        send_cmd(OP_INIT, 40, 1'b0);
        ready_mode = 2;
        random_mix();
        wait_drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== tb/vde_asserts.sv ====
`timescale 1ns/1ps
module vde_asserts (
    input logic                       clk,
    input logic                       reset,
    input logic                       dec_valid,
    input logic [vde_pkg::VAR_W-1:0]  dec_var,
    input logic                       dec_phase,
    input logic                       dec_empty,
    input logic                       dec_ready,
    input logic                       busy
);

    // A stalled decision keeps its data until it is taken
    hold_decision: assert property (@(posedge clk) disable iff (reset)
        dec_valid && !dec_ready |=> dec_valid && $stable({dec_var, dec_phase, dec_empty}))
        else $error("decision output changed while stalled");

    idle_in_reset: assert property (@(posedge clk) reset |-> !busy && !dec_valid)
        else $error("engine busy or decision valid during reset");

    empty_has_no_var: assert property (@(posedge clk) disable iff (reset)
        dec_valid && dec_empty |-> dec_var == '0)
        else $error("empty decision carries a variable number");

endmodule

bind vde_top vde_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .dec_valid (dec_valid),
    .dec_var   (dec_var),
    .dec_phase (dec_phase),
    .dec_empty (dec_empty),
    .dec_ready (dec_ready),
    .busy      (busy)
);

// ==== design/vde_top.sv ====
`timescale 1ns/1ps
module vde_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_valid,
    input  vde_pkg::op_e               cmd_op,
    input  logic [vde_pkg::VAR_W-1:0]  cmd_var,
    input  logic                       cmd_value,
    output logic                       cmd_ready,
    output logic                       dec_valid,
    output logic [vde_pkg::VAR_W-1:0]  dec_var,
    output logic                       dec_phase,
    output logic                       dec_empty,
    input  logic                       dec_ready,
    output logic                       busy
);
    import vde_pkg::*;

    heap_cmd_if cmd_bus ();
    heap_mem_if mem_bus ();

    logic      dec_push;
    logic      dec_full;
    decision_t dec_data;

    // ============================
    // Input side
    // ============================
    cmd_intake u_intake (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_var   (cmd_var),
        .cmd_value (cmd_value),
        .cmd_ready (cmd_ready),
        .down      (cmd_bus.intake)
    );

    // ============================
    // Heap
    // ============================
    heap_engine u_engine (
        .clk    (clk),
        .reset  (reset),
        .up     (cmd_bus.engine),
        .mem    (mem_bus.engine),
        .push   (dec_push),
        .result (dec_data),
        .full   (dec_full),
        .busy   (busy)
    );

    heap_store u_store (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus.store)
    );

    // Output side
    decision_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (dec_push),
        .din       (dec_data),
        .full      (dec_full),
        .dec_valid (dec_valid),
        .dec_var   (dec_var),
        .dec_phase (dec_phase),
        .dec_empty (dec_empty),
        .dec_ready (dec_ready)
    );

endmodule

// ==== design/decision_fifo.sv ====
`timescale 1ns/1ps
module decision_fifo (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  vde_pkg::decision_t         din,
    output logic                       full,
    output logic                       dec_valid,
    output logic [vde_pkg::VAR_W-1:0]  dec_var,
    output logic                       dec_phase,
    output logic                       dec_empty,
    input  logic                       dec_ready
);
    import vde_pkg::*;

    decision_t  slots [2];
    decision_t  head;
    logic       wr_ptr, rd_ptr;
    logic [1:0] count;
    logic       do_push, do_pop;

    assign full      = (count == 2'd2);
    assign dec_valid = (count != 2'd0);
    assign do_push   = push && !full;
    assign do_pop    = dec_valid && dec_ready;

    // Head entry onto the output ports
    assign head      = slots[rd_ptr];
    assign dec_var   = head.var_id;
    assign dec_phase = head.phase;
    assign dec_empty = head.empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (do_push) wr_ptr <= !wr_ptr;
            if (do_pop)  rd_ptr <= !rd_ptr;
            count <= count + {1'b0, do_push} - {1'b0, do_pop};
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= din;
        end
    end

endmodule

// ==== heap/heap_engine.sv ====
`timescale 1ns/1ps
module heap_engine (
    input  logic               clk,
    input  logic               reset,
    heap_cmd_if.engine         up,
    heap_mem_if.engine         mem,
    output logic               push,
    output vde_pkg::decision_t result,
    input  logic               full,
    output logic               busy
);
    import vde_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE, S_HIDE, S_DOWN, S_DSWAP, S_LOOK,
        S_UNHIDE, S_BUMP, S_UP, S_USWAP, S_INIT
    } state_e;

    state_e           state;
    logic [VAR_W-1:0] size;
    logic [VAR_W-1:0] cur;
    logic [VAR_W-1:0] nxt;
    logic [VAR_W-1:0] var_q;
    logic             value_q;
    op_e              op_q;

    logic             take;
    logic [VAR_W:0]   left_w, right_w;
    logic [VAR_W-1:0] parent, hole_parent, best;
    heap_entry_t      best_ent;
    logic             up_swap;
    logic             hole_up;

    // Higher score wins, lower variable number breaks a tie
    function automatic logic better(input heap_entry_t a, input heap_entry_t b);
        return (a.score > b.score) || (a.score == b.score && a.var_id < b.var_id);
    endfunction

    assign up.ready = (state == S_IDLE) && !(up.op == OP_DECIDE && full);
    assign take     = up.valid && up.ready;
    assign busy     = (state != S_IDLE);

    // ============================
    // Slot arithmetic and reads
    // ============================
    assign left_w      = {cur, 1'b1};
    assign right_w     = {cur, 1'b0} + (VAR_W+1)'(2);
    assign parent      = (cur - 1'b1) >> 1;
    assign hole_parent = (mem.pos_slot - 1'b1) >> 1;

    always_comb begin
        case (state)
            S_IDLE:  mem.rd_a = '0;
            S_HIDE:  mem.rd_a = size - 1'b1;
            default: mem.rd_a = cur;
        endcase
        case (state)
            S_UP:    mem.rd_b = parent;
            S_HIDE:  mem.rd_b = hole_parent;
            default: mem.rd_b = left_w[VAR_W-1:0];
        endcase
    end
    assign mem.rd_c    = right_w[VAR_W-1:0];
    assign mem.pos_var = var_q;

    // Largest of the node and its live children
    always_comb begin
        best     = cur;
        best_ent = mem.ent_a;
        if (left_w < {1'b0, size} && better(mem.ent_b, best_ent)) begin
            best     = left_w[VAR_W-1:0];
            best_ent = mem.ent_b;
        end
        if (right_w < {1'b0, size} && better(mem.ent_c, best_ent)) begin
            best = right_w[VAR_W-1:0];
        end
    end

    assign up_swap = (cur != '0) && better(mem.ent_a, mem.ent_b);
    // Last entry dropped into the hole may beat the hole's parent
    assign hole_up = (mem.pos_slot != '0) && better(mem.ent_a, mem.ent_b);

    // ============================
    // Store writes
    // ============================
    always_comb begin
        mem.swap_en = 1'b0;
        mem.swap_x  = cur;
        mem.swap_y  = nxt;
        case (state)
            S_HIDE: begin
                mem.swap_en = (mem.pos_slot < size);
                mem.swap_x  = mem.pos_slot;
                mem.swap_y  = size - 1'b1;
            end
            S_UNHIDE: begin
                mem.swap_en = 1'b1;
                mem.swap_y  = size;
            end
            S_DSWAP: mem.swap_en = 1'b1;
            S_USWAP: begin
                mem.swap_en = 1'b1;
                mem.swap_y  = parent;
            end
            default: ;
        endcase
    end

    assign mem.bump_en   = (state == S_BUMP);
    assign mem.bump_slot = cur;
    assign mem.init_en   = (state == S_INIT) && (cur < size);
    assign mem.init_slot = cur;
    assign mem.phase_we  = (state == S_HIDE);
    assign mem.phase_var = var_q;
    assign mem.phase_val = value_q;

    // Decide answers straight from the root
    assign push = take && (up.op == OP_DECIDE);
    always_comb begin
        result.empty  = (size == '0);
        result.var_id = result.empty ? '0 : mem.ent_a.var_id;
        result.phase  = !result.empty && mem.phase_out;
    end

    // ============================
    // FSM
    // ============================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
            size  <= '0;
            cur   <= '0;
        end else begin
            case (state)
                S_IDLE: if (take) begin
                    case (up.op)
                        OP_INIT: begin
                            state <= S_INIT;
                            size  <= up.var_id;
                            cur   <= '0;
                        end
                        OP_ASSIGN:            state <= S_HIDE;
                        OP_UNASSIGN, OP_BUMP: state <= S_LOOK;
                        default:              state <= S_IDLE;
                    endcase
                end
                S_HIDE: if (mem.pos_slot < size) begin
                    size  <= size - 1'b1;
                    cur   <= mem.pos_slot;
                    state <= hole_up ? S_UP : S_DOWN;
                end else begin
                    state <= S_IDLE;
                end
                S_DOWN: if (best != cur) begin
                    nxt   <= best;
                    state <= S_DSWAP;
                end else begin
                    state <= S_IDLE;
                end
                S_DSWAP: begin
                    cur   <= nxt;
                    state <= S_DOWN;
                end
                S_LOOK: begin
                    cur <= mem.pos_slot;
                    if (op_q == OP_BUMP) begin
                        state <= S_BUMP;
                    end else begin
                        state <= (mem.pos_slot >= size) ? S_UNHIDE : S_IDLE;
                    end
                end
                S_UNHIDE: begin
                    cur   <= size;
                    size  <= size + 1'b1;
                    state <= S_UP;
                end
                S_BUMP:  state <= (cur < size) ? S_UP : S_IDLE;
                S_UP:    state <= up_swap ? S_USWAP : S_IDLE;
                S_USWAP: begin
                    cur   <= parent;
                    state <= S_UP;
                end
                S_INIT: if (cur < size) begin
                    cur <= cur + 1'b1;
                end else begin
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            var_q   <= up.var_id;
            value_q <= up.value;
            op_q    <= up.op;
        end
    end

endmodule

// ==== heap/heap_store.sv ====
`timescale 1ns/1ps
module heap_store (
    input  logic       clk,
    input  logic       reset,
    heap_mem_if.store  mem
);
    import vde_pkg::*;

    heap_entry_t      heap_mem  [MAX_VARS];
    logic [VAR_W-1:0] pos_mem   [MAX_VARS];
    logic             phase_mem [MAX_VARS];

    heap_entry_t      ent_x, ent_y, init_ent;
    logic [SCORE_W-1:0] bumped;

    function automatic logic [SLOT_W-1:0] slot(input logic [VAR_W-1:0] s);
        return s[SLOT_W-1:0];
    endfunction

    // Variables are numbered from one
    function automatic logic [SLOT_W-1:0] var_slot(input logic [VAR_W-1:0] v);
        logic [VAR_W-1:0] d;
        d = v - 1'b1;
        return d[SLOT_W-1:0];
    endfunction

    assign mem.ent_a     = heap_mem[slot(mem.rd_a)];
    assign mem.ent_b     = heap_mem[slot(mem.rd_b)];
    assign mem.ent_c     = heap_mem[slot(mem.rd_c)];
    assign mem.pos_slot  = pos_mem[var_slot(mem.pos_var)];
    assign mem.phase_out = phase_mem[var_slot(heap_mem[0].var_id)];

    assign ent_x           = heap_mem[slot(mem.swap_x)];
    assign ent_y           = heap_mem[slot(mem.swap_y)];
    assign bumped          = heap_mem[slot(mem.bump_slot)].score + BUMP_INCREMENT;
    assign init_ent.score  = '0;
    assign init_ent.var_id = mem.init_slot + 1'b1;

    always_ff @(posedge clk) begin
        if (!reset) begin
            if (mem.init_en) begin
                heap_mem[slot(mem.init_slot)]  <= init_ent;
                pos_mem[slot(mem.init_slot)]   <= mem.init_slot;
                phase_mem[slot(mem.init_slot)] <= 1'b0;
            end else if (mem.swap_en) begin
                // Exchange entries and point both variables at their new slots
                heap_mem[slot(mem.swap_x)]    <= ent_y;
                heap_mem[slot(mem.swap_y)]    <= ent_x;
                pos_mem[var_slot(ent_y.var_id)] <= mem.swap_x;
                pos_mem[var_slot(ent_x.var_id)] <= mem.swap_y;
            end else if (mem.bump_en) begin
                heap_mem[slot(mem.bump_slot)].score <= bumped;
            end
            if (mem.phase_we) begin
                phase_mem[var_slot(mem.phase_var)] <= mem.phase_val;
            end
        end
    end

endmodule

// ==== design/cmd_intake.sv ====
`timescale 1ns/1ps
module cmd_intake (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_valid,
    input  vde_pkg::op_e               cmd_op,
    input  logic [vde_pkg::VAR_W-1:0]  cmd_var,
    input  logic                       cmd_value,
    output logic                       cmd_ready,
    heap_cmd_if.intake                 down
);
    import vde_pkg::*;

    logic [VAR_W-1:0] var_count;
    logic [VAR_W-1:0] init_count;
    logic             take;
    logic             keep;

    // Slot is free, or its command leaves this cycle
    assign cmd_ready = !down.valid || down.ready;
    assign take      = cmd_valid && cmd_ready;

    // Bad counts give an empty heap
    assign init_count = (cmd_var == '0 || cmd_var > VAR_W'(MAX_VARS)) ? '0 : cmd_var;

    always_comb begin
        case (cmd_op)
            OP_INIT, OP_DECIDE: keep = 1'b1;
            OP_ASSIGN, OP_UNASSIGN, OP_BUMP:
                keep = (cmd_var != '0) && (cmd_var <= var_count);
            default: keep = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            down.valid <= 1'b0;
            var_count  <= '0;
        end else if (take) begin
            // Out-of-range commands are swallowed here
            down.valid <= keep;
            if (cmd_op == OP_INIT) begin
                var_count <= init_count;
            end
        end else if (down.ready) begin
            down.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            down.op     <= cmd_op;
            down.var_id <= (cmd_op == OP_INIT) ? init_count : cmd_var;
            down.value  <= cmd_value;
        end
    end

endmodule

// ==== common/heap_mem_if.sv ====
`timescale 1ns/1ps
interface heap_mem_if;
    import vde_pkg::*;

    // Read side
    logic [VAR_W-1:0] rd_a, rd_b, rd_c;
    heap_entry_t      ent_a, ent_b, ent_c;
    logic [VAR_W-1:0] pos_var, pos_slot;
    logic             phase_out;

    // Write side takes effect at the clock edge
    logic             swap_en, bump_en, init_en, phase_we;
    logic [VAR_W-1:0] swap_x, swap_y, bump_slot, init_slot, phase_var;
    logic             phase_val;

    modport engine (
        output rd_a, rd_b, rd_c, pos_var,
        output swap_en, swap_x, swap_y, bump_en, bump_slot,
        output init_en, init_slot, phase_we, phase_var, phase_val,
        input  ent_a, ent_b, ent_c, pos_slot, phase_out
    );

    modport store (
        input  rd_a, rd_b, rd_c, pos_var,
        input  swap_en, swap_x, swap_y, bump_en, bump_slot,
        input  init_en, init_slot, phase_we, phase_var, phase_val,
        output ent_a, ent_b, ent_c, pos_slot, phase_out
    );

endinterface

// ==== common/heap_cmd_if.sv ====
`timescale 1ns/1ps
interface heap_cmd_if;
    import vde_pkg::*;

    logic             valid;
    logic             ready;
    op_e              op;
    logic [VAR_W-1:0] var_id;
    logic             value;

    modport intake (
        output valid, op, var_id, value,
        input  ready
    );

    modport engine (
        input  valid, op, var_id, value,
        output ready
    );

endinterface

// ==== common/vde_pkg.sv ====
package vde_pkg;

    // ============================
    // Sizes
    // ============================
    localparam int MAX_VARS = 64;
    // Variable numbers run 1..MAX_VARS, so one bit more than a slot address
    localparam int VAR_W    = $clog2(MAX_VARS) + 1;
    localparam int SLOT_W   = $clog2(MAX_VARS);
    localparam int SCORE_W  = 32;

    // Fixed activity step
    localparam logic [SCORE_W-1:0] BUMP_INCREMENT = 32'd10000;

    // ============================
    // Commands and records
    // ============================
    typedef enum logic [2:0] {
        OP_INIT     = 3'd0,
        OP_ASSIGN   = 3'd1,
        OP_UNASSIGN = 3'd2,
        OP_BUMP     = 3'd3,
        OP_DECIDE   = 3'd4
    } op_e;

    typedef struct packed {
        logic [SCORE_W-1:0] score;
        logic [VAR_W-1:0]   var_id;
    } heap_entry_t;

    typedef struct packed {
        logic [VAR_W-1:0] var_id;
        logic             phase;
        logic             empty;
    } decision_t;

endpackage
